//--- all.f
rtl/ddr_pkg.sv
rtl/burst_if.sv
rtl/bank_arbiter.sv
rtl/burst_handler.sv
rtl/timing_controller.sv
rtl/response_returner.sv
rtl/mem_ctrl_top.sv
test/ddr_mem_model.sv
test/tb_mem_ctrl.sv

//--- rtl/bank_arbiter.sv
`timescale 1ns/100ps

module bank_arbiter (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        rd_req,
	input  ddr_pkg::addr_t              rd_addr,
	input  logic [ddr_pkg::tag_w-1:0]   rd_tag,
	output logic                        rd_ack,
	input  logic                        wr_req,
	input  ddr_pkg::addr_t              wr_addr,
	input  logic [ddr_pkg::data_w-1:0]  wr_data,
	input  logic [ddr_pkg::tag_w-1:0]   wr_tag,
	output logic                        wr_ack,
	burst_if.source                     req_out
);
	import ddr_pkg::*;

	logic     rd_elig;     // read client waiting and not yet acked
	logic     wr_elig;
	logic     pick_wr;
	logic     wr_first;    // priority flips after each grant
	logic     beat_valid;
	mem_req_t beat;

	assign rd_elig = rd_req && !rd_ack;
	assign wr_elig = wr_req && !wr_ack;
	assign pick_wr = wr_elig && (!rd_elig || wr_first);

	assign req_out.valid   = beat_valid;
	assign req_out.payload = beat;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			beat_valid <= 1'b0;
			rd_ack     <= 1'b0;
			wr_ack     <= 1'b0;
			wr_first   <= 1'b0;
		end else begin
			if (beat_valid) begin
				if (req_out.ready) begin
					beat_valid <= 1'b0;
					if (beat.kind == wr)
						wr_ack <= 1'b1;  // ack the cycle after the handler takes it
					else
						rd_ack <= 1'b1;
				end
			end else if (rd_elig || wr_elig) begin
				beat_valid <= 1'b1;
				wr_first   <= !pick_wr;
			end

			// four-phase release once the client lets go
			if (rd_ack && !rd_req)
				rd_ack <= 1'b0;
			if (wr_ack && !wr_req)
				wr_ack <= 1'b0;
		end
	end

	// capture the winning client's fields while nothing is pending
	always_ff @(posedge clk) begin
		if (!beat_valid) begin
			if (pick_wr) begin
				beat.kind <= wr;
				beat.addr <= wr_addr;
				beat.data <= wr_data;
				beat.tag  <= wr_tag;
			end else begin
				beat.kind <= rd;
				beat.addr <= rd_addr;
				beat.data <= '0;
				beat.tag  <= rd_tag;
			end
		end
	end

endmodule

//--- rtl/burst_handler.sv
`timescale 1ns/100ps

module burst_handler (
	input  logic                                                clk,
	input  logic                                                rst_n,
	burst_if.sink                                               req_in,
	burst_if.source                                             rsp_out,
	output ddr_pkg::burst_state_t [ddr_pkg::num_bursts-1:0]     slot_state,
	output ddr_pkg::addr_t [ddr_pkg::num_bursts-1:0]            slot_addr,
	output ddr_pkg::req_kind_t [ddr_pkg::num_bursts-1:0]        slot_kind,
	input  ddr_pkg::ddr_cmd_t                                   cmd,
	input  logic [ddr_pkg::slot_w-1:0]                          cmd_slot,
	output logic                                                cmd_done,
	output logic                                                cs_n,
	output logic [13:0]                                         ca,
	output logic [ddr_pkg::data_w-1:0]                          dq_out,
	output logic                                                dq_oe,
	input  logic [ddr_pkg::data_w-1:0]                          dq_in
);
	import ddr_pkg::*;

	logic [num_bursts-1:0][burst_len-1:0] mask;  // beats owned by a request
	logic [data_w-1:0] beat_data [num_bursts][burst_len];
	logic [tag_w-1:0]  beat_tag  [num_bursts][burst_len];

	logic [slot_w-1:0] cur_slot, free_slot, fill_slot, ret_slot, ret_pick, act_slot;
	logic [beat_w-1:0] fill_cnt, in_beat, ret_beat, dq_beat;
	logic              cur_open, join_ok, have_free, do_join, do_new, ret_found, ret_on;
	logic              data_on, in_win;
	logic [1:0]        pin_step;  // 0 idle, 1 part 1 on pins, 2 part 2 on pins
	logic [wait_w-1:0] d_cnt, lat, d_off;
	ddr_cmd_t          cmd_q;
	mem_req_t          req;
	mem_rsp_t          rsp_beat;

	function automatic logic same_block(addr_t a, addr_t b);
		return {a.bank_group, a.bank, a.row, a.column[5:beat_w]} ==
			{b.bank_group, b.bank, b.row, b.column[5:beat_w]};
	endfunction

	function automatic logic [13:0] ca_part1(ddr_cmd_t c, addr_t a);
		logic [13:0] v;
		case (c)
			activate:  v = {2'b00, a.bank_group, a.bank, a.row[5:0], 2'b00};
			read_cmd:  v = {4'b0000, a.bank_group, a.bank, 1'b1, 5'b11101};
			write_cmd: v = {4'b0000, a.bank_group, a.bank, 1'b1, 5'b01101};
			precharge: v = {4'b0000, a.bank_group, a.bank, 6'b011011};
			default:   v = '0;
		endcase
		return v;
	endfunction

	// all_beats low marks a partial write
	function automatic logic [13:0] ca_part2(ddr_cmd_t c, addr_t a, logic all_beats);
		logic [13:0] v;
		case (c)
			activate:  v = {2'b00, a.row[11:6], 6'b000000};
			read_cmd:  v = {3'b000, 1'b1, 1'b1, 3'b000, a.column[5:beat_w], 4'b0000};
			write_cmd: v = {3'b000, all_beats, 1'b1, 3'b000, a.column[5:beat_w], 4'b0000};
			default:   v = '0;
		endcase
		return v;
	endfunction

	assign req      = req_in.payload;
	assign in_beat  = req.addr.column[beat_w-1:0];
	assign cur_open = slot_state[cur_slot] == filling || slot_state[cur_slot] == almost_done;
	assign join_ok  = cur_open && slot_kind[cur_slot] == req.kind &&
		same_block(slot_addr[cur_slot], req.addr) && !mask[cur_slot][in_beat];
	assign req_in.ready = join_ok || have_free;
	assign do_join   = req_in.valid && join_ok;
	assign do_new    = req_in.valid && !join_ok && have_free;
	assign fill_slot = do_join ? cur_slot : free_slot;

	always_comb begin  // lowest empty and lowest returning slot
		have_free = 1'b0;
		free_slot = '0;
		ret_found = 1'b0;
		ret_pick  = '0;
		for (int i = num_bursts - 1; i >= 0; i--) begin
			if (slot_state[i] == empty) begin
				have_free = 1'b1;
				free_slot = slot_w'(i);
			end
			if (slot_state[i] == returning) begin
				ret_found = 1'b1;
				ret_pick  = slot_w'(i);
			end
		end
	end

	always_comb begin  // lowest beat still to report
		ret_beat = '0;
		for (int b = burst_len - 1; b >= 0; b--) begin
			if (mask[ret_slot][b])
				ret_beat = beat_w'(b);
		end
		rsp_beat.kind = slot_kind[ret_slot];
		rsp_beat.data = beat_data[ret_slot][ret_beat];
		rsp_beat.tag  = beat_tag[ret_slot][ret_beat];
	end

	assign rsp_out.valid   = ret_on && |mask[ret_slot];
	assign rsp_out.payload = rsp_beat;

	// data phase window counted from the column command's last pin cycle
	assign lat     = (slot_kind[act_slot] == wr) ? wait_w'(wr_to_data) : wait_w'(rd_to_data);
	assign d_off   = d_cnt - lat;
	assign dq_beat = d_off[beat_w-1:0];
	assign in_win  = data_on && d_cnt >= lat && d_off < burst_len;
	assign dq_oe   = in_win && slot_kind[act_slot] == wr && mask[act_slot][dq_beat];
	assign dq_out  = beat_data[act_slot][dq_beat];

	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < num_bursts; i++)
				slot_state[i] <= empty;
			mask     <= '0;
			cur_slot <= '0;
			fill_cnt <= '0;
			ret_on   <= 1'b0;
			ret_slot <= '0;
			cs_n     <= 1'b1;
			ca       <= '0;
			cmd_q    <= none;
			act_slot <= '0;
			pin_step <= 2'd0;
			cmd_done <= 1'b0;
			data_on  <= 1'b0;
			d_cnt    <= '0;
		end else begin
			if (do_join) begin
				mask[cur_slot][in_beat] <= 1'b1;
				fill_cnt <= fill_cnt + 1'b1;
				if (fill_cnt == beat_w'(burst_len / 2 - 1))
					slot_state[cur_slot] <= almost_done;
			end else if (cur_open) begin
				slot_state[cur_slot] <= full;  // idle cycle or other block
			end
			if (do_new) begin
				slot_state[free_slot] <= filling;
				mask[free_slot] <= burst_len'(1) << in_beat;
				cur_slot <= free_slot;
				fill_cnt <= beat_w'(1);
			end

			cmd_done <= 1'b0;
			case (pin_step)
				2'd0: if (cmd != none) begin
					cmd_q    <= cmd;
					act_slot <= cmd_slot;
					cs_n     <= 1'b0;
					ca       <= ca_part1(cmd, slot_addr[cmd_slot]);
					cmd_done <= (cmd == precharge);  // single pin cycle
					pin_step <= 2'd1;
					if (cmd == activate)
						slot_state[cmd_slot] <= in_service;
				end
				2'd1: begin
					cs_n <= 1'b1;
					if (cmd_q == precharge) begin
						ca       <= '0;
						pin_step <= 2'd0;
					end else begin
						ca       <= ca_part2(cmd_q, slot_addr[act_slot], &mask[act_slot]);
						cmd_done <= 1'b1;
						pin_step <= 2'd2;
					end
				end
				default: begin
					ca       <= '0;
					pin_step <= 2'd0;
				end
			endcase

			if (cmd_done && (cmd_q == read_cmd || cmd_q == write_cmd)) begin
				data_on <= 1'b1;
				d_cnt   <= wait_w'(1);
			end else if (data_on) begin
				d_cnt <= d_cnt + 1'b1;
				if (d_cnt == lat + wait_w'(burst_len - 1))
					data_on <= 1'b0;
			end
			if (cmd_done && cmd_q == precharge)
				slot_state[act_slot] <= returning;

			if (!ret_on) begin
				if (ret_found) begin
					ret_on   <= 1'b1;  // lock one slot until it drains
					ret_slot <= ret_pick;
				end
			end else if (mask[ret_slot] == '0) begin
				slot_state[ret_slot] <= empty;
				ret_on <= 1'b0;
			end else if (rsp_out.ready) begin
				mask[ret_slot][ret_beat] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_new) begin
			slot_addr[free_slot] <= req.addr;
			slot_kind[free_slot] <= req.kind;
		end
		if (do_join || do_new) begin
			beat_data[fill_slot][in_beat] <= req.data;
			beat_tag[fill_slot][in_beat]  <= req.tag;
		end
		if (in_win && slot_kind[act_slot] == rd && mask[act_slot][dq_beat])
			beat_data[act_slot][dq_beat] <= dq_in;  // read beat from the device
	end

endmodule

//--- rtl/burst_if.sv
`timescale 1ns/100ps

// one valid/ready channel between two blocks of the controller
interface burst_if #(
	parameter type payload_t = logic
);

	logic     valid;    // payload is meaningful
	logic     ready;    // sink can take it this cycle
	payload_t payload;  // held by the source while ready is low

	modport source (
		output valid,
		output payload,
		input  ready
	);

	modport sink (
		input  valid,
		input  payload,
		output ready
	);

endinterface

//--- rtl/ddr_pkg.sv
package ddr_pkg;

	localparam int num_bursts = 4;   // burst slots in the handler
	localparam int burst_len  = 16;  // beats per burst
	localparam int data_w     = 32;
	localparam int tag_w      = 4;   // host request index

	localparam int t_rcd      = 4;   // activate end to column command
	localparam int rd_to_data = 11;  // read command end to first beat
	localparam int wr_to_data = 8;   // write command end to first beat
	localparam int t_rp       = 3;   // precharge to next activate, same bank

	localparam int slot_w = $clog2(num_bursts);
	localparam int beat_w = $clog2(burst_len);
	localparam int wait_w = $clog2(rd_to_data + burst_len + 1);  // data phase counters

	// low beat_w column bits pick the beat inside a burst
	typedef struct packed {
		logic [1:0]  bank_group;
		logic [1:0]  bank;
		logic [11:0] row;
		logic [5:0]  column;
	} addr_t;

	typedef enum logic {
		rd,
		wr
	} req_kind_t;

	typedef enum logic [2:0] {
		empty,
		filling,
		almost_done,  // half the beats collected
		full,
		in_service,
		returning
	} burst_state_t;

	typedef enum logic [2:0] {
		none,
		activate,
		read_cmd,
		write_cmd,
		precharge
	} ddr_cmd_t;

	typedef struct packed {
		req_kind_t          kind;
		addr_t              addr;
		logic [data_w-1:0]  data;  // unused for reads
		logic [tag_w-1:0]   tag;
	} mem_req_t;

	typedef struct packed {
		req_kind_t          kind;
		logic [data_w-1:0]  data;
		logic [tag_w-1:0]   tag;
	} mem_rsp_t;

endpackage

//--- rtl/mem_ctrl_top.sv
`timescale 1ns/100ps

module mem_ctrl_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        rd_req,
	input  ddr_pkg::addr_t              rd_addr,
	input  logic [ddr_pkg::tag_w-1:0]   rd_tag,
	output logic                        rd_ack,
	input  logic                        wr_req,
	input  ddr_pkg::addr_t              wr_addr,
	input  logic [ddr_pkg::data_w-1:0]  wr_data,
	input  logic [ddr_pkg::tag_w-1:0]   wr_tag,
	output logic                        wr_ack,
	output logic                        rsp_req,
	output ddr_pkg::req_kind_t          rsp_kind,
	output logic [ddr_pkg::data_w-1:0]  rsp_data,
	output logic [ddr_pkg::tag_w-1:0]   rsp_tag,
	input  logic                        rsp_ack,
	output logic                        cs_n,
	output logic [13:0]                 ca,
	output logic [ddr_pkg::data_w-1:0]  dq_out,
	output logic                        dq_oe,
	input  logic [ddr_pkg::data_w-1:0]  dq_in
);
	import ddr_pkg::*;

	burst_if #(.payload_t(mem_req_t)) req_bus ();  // arbiter to handler
	burst_if #(.payload_t(mem_rsp_t)) rsp_bus ();  // handler to returner

	burst_state_t [num_bursts-1:0] slot_state;
	addr_t [num_bursts-1:0]        slot_addr;
	req_kind_t [num_bursts-1:0]    slot_kind;
	ddr_cmd_t                      cmd;
	logic [slot_w-1:0]             cmd_slot;
	logic                          cmd_done;

	bank_arbiter u_bank_arbiter (
		.clk     (clk),
		.rst_n   (rst_n),
		.rd_req  (rd_req),
		.rd_addr (rd_addr),
		.rd_tag  (rd_tag),
		.rd_ack  (rd_ack),
		.wr_req  (wr_req),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wr_tag  (wr_tag),
		.wr_ack  (wr_ack),
		.req_out (req_bus.source)
	);

	burst_handler u_burst_handler (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_in     (req_bus.sink),
		.rsp_out    (rsp_bus.source),
		.slot_state (slot_state),
		.slot_addr  (slot_addr),
		.slot_kind  (slot_kind),
		.cmd        (cmd),
		.cmd_slot   (cmd_slot),
		.cmd_done   (cmd_done),
		.cs_n       (cs_n),
		.ca         (ca),
		.dq_out     (dq_out),
		.dq_oe      (dq_oe),
		.dq_in      (dq_in)
	);

	timing_controller u_timing_controller (
		.clk        (clk),
		.rst_n      (rst_n),
		.slot_state (slot_state),
		.slot_addr  (slot_addr),
		.slot_kind  (slot_kind),
		.cmd        (cmd),
		.cmd_slot   (cmd_slot),
		.cmd_done   (cmd_done)
	);

	response_returner u_response_returner (
		.clk      (clk),
		.rst_n    (rst_n),
		.rsp_in   (rsp_bus.sink),
		.rsp_req  (rsp_req),
		.rsp_kind (rsp_kind),
		.rsp_data (rsp_data),
		.rsp_tag  (rsp_tag),
		.rsp_ack  (rsp_ack)
	);

endmodule

//--- rtl/response_returner.sv
`timescale 1ns/100ps

module response_returner (
	input  logic                        clk,
	input  logic                        rst_n,
	burst_if.sink                       rsp_in,
	output logic                        rsp_req,
	output ddr_pkg::req_kind_t          rsp_kind,
	output logic [ddr_pkg::data_w-1:0]  rsp_data,
	output logic [ddr_pkg::tag_w-1:0]   rsp_tag,
	input  logic                        rsp_ack
);
	import ddr_pkg::*;

	mem_rsp_t held;  // the one response in flight to the host
	logic     take;

	// new beat only after the host finished the last handshake
	assign rsp_in.ready = !rsp_req && !rsp_ack;
	assign take         = rsp_in.valid && rsp_in.ready;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			rsp_req <= 1'b0;
		end else if (take) begin
			rsp_req <= 1'b1;
		end else if (rsp_req && rsp_ack) begin
			rsp_req <= 1'b0;  // ack seen, wait for it to fall
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			held <= rsp_in.payload;
	end

	assign rsp_kind = held.kind;
	assign rsp_data = held.data;
	assign rsp_tag  = held.tag;

endmodule

//--- rtl/timing_controller.sv
`timescale 1ns/100ps

module timing_controller (
	input  logic                                            clk,
	input  logic                                            rst_n,
	input  ddr_pkg::burst_state_t [ddr_pkg::num_bursts-1:0] slot_state,
	input  ddr_pkg::addr_t [ddr_pkg::num_bursts-1:0]        slot_addr,
	input  ddr_pkg::req_kind_t [ddr_pkg::num_bursts-1:0]    slot_kind,
	output ddr_pkg::ddr_cmd_t                               cmd,
	output logic [ddr_pkg::slot_w-1:0]                      cmd_slot,
	input  logic                                            cmd_done
);
	import ddr_pkg::*;

	typedef enum logic [2:0] {
		tc_idle,
		tc_act,   // activate on the pins
		tc_rcd,
		tc_col,   // column command on the pins
		tc_data,
		tc_pre    // precharge on the pins
	} tc_state_t;

	tc_state_t         st;
	logic [wait_w-1:0] cnt;
	logic [wait_w-1:0] rp_cnt;     // tRP still running for last_bank
	logic [3:0]        last_bank;  // bank group and bank just closed
	logic [slot_w-1:0] pick;
	logic              pick_found;
	logic              go;

	always_comb begin  // lowest full slot
		pick_found = 1'b0;
		pick       = '0;
		for (int i = num_bursts - 1; i >= 0; i--) begin
			if (slot_state[i] == full) begin
				pick_found = 1'b1;
				pick       = slot_w'(i);
			end
		end
	end

	// another bank may open while the closed one is still precharging
	assign go = pick_found &&
		(rp_cnt == '0 || {slot_addr[pick].bank_group, slot_addr[pick].bank} != last_bank);

	always_ff @(posedge clk) begin
		if (rst_n) begin
			st        <= tc_idle;
			cmd       <= none;
			cmd_slot  <= '0;
			cnt       <= '0;
			rp_cnt    <= '0;
			last_bank <= '0;
		end else begin
			cmd <= none;  // every command lasts one cycle
			if (rp_cnt != '0)
				rp_cnt <= rp_cnt - 1'b1;
			case (st)
				tc_idle: if (go) begin
					cmd      <= activate;
					cmd_slot <= pick;
					st       <= tc_act;
				end
				tc_act: if (cmd_done) begin
					cnt <= wait_w'(t_rcd - 1);
					st  <= tc_rcd;
				end
				tc_rcd: if (cnt <= wait_w'(1)) begin
					cmd <= (slot_kind[cmd_slot] == wr) ? write_cmd : read_cmd;
					st  <= tc_col;
				end else begin
					cnt <= cnt - 1'b1;
				end
				tc_col: if (cmd_done) begin
					// latency plus all beats before the bank closes
					if (slot_kind[cmd_slot] == wr)
						cnt <= wait_w'(wr_to_data + burst_len - 1);
					else
						cnt <= wait_w'(rd_to_data + burst_len - 1);
					st <= tc_data;
				end
				tc_data: if (cnt <= wait_w'(1)) begin
					cmd <= precharge;
					st  <= tc_pre;
				end else begin
					cnt <= cnt - 1'b1;
				end
				default: if (cmd_done) begin
					rp_cnt    <= wait_w'(t_rp);
					last_bank <= {slot_addr[cmd_slot].bank_group, slot_addr[cmd_slot].bank};
					st        <= tc_idle;
				end
			endcase
		end
	end

endmodule

//--- test/ddr_mem_model.sv
`timescale 1ns/100ps

module ddr_mem_model (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        cs_n,
	input  logic [13:0]                 ca,
	input  logic [ddr_pkg::data_w-1:0]  dq_out,
	input  logic                        dq_oe,
	output logic [ddr_pkg::data_w-1:0]  dq_in,
	output int                          act_count
);
	import ddr_pkg::*;

	logic [data_w-1:0] mem [logic [21:0]];  // sparse array, unwritten words read as zero
	logic [11:0]       open_row [16];        // indexed by {bank_group, bank}
	logic [13:0]       part1;
	logic              part2_due;
	logic              data_on;
	logic              is_rd;
	logic [21:0]       base;                 // first word of the burst in flight
	int                k;                    // cycles since the column command ended
	int                beat;

	always @(posedge clk) begin
		if (rst_n) begin
			part2_due <= 1'b0;
			data_on   <= 1'b0;
			act_count <= 0;
			dq_in     <= '0;
		end else begin
			if (!cs_n) begin
				part1     <= ca;
				part2_due <= (ca[1:0] != 2'b11);  // precharge has one cycle only
			end
			if (part2_due) begin
				part2_due <= 1'b0;
				if (part1[1:0] == 2'b00) begin
					open_row[part1[11:8]] <= {ca[11:6], part1[7:2]};
					act_count <= act_count + 1;
				end else begin
					base    <= {part1[9:6], open_row[part1[9:6]], ca[5:4], 4'b0000};
					is_rd   <= part1[4];
					data_on <= 1'b1;
					k       <= 1;
				end
			end
			if (data_on) begin
				k <= k + 1;
				// drive one cycle ahead so the beat is stable at the capture edge
				beat = k + 1 - rd_to_data;
				if (is_rd && beat >= 0 && beat < burst_len)
					dq_in <= mem.exists({base[21:4], 4'(beat)}) ?
						mem[{base[21:4], 4'(beat)}] : '0;
				beat = k - wr_to_data;
				if (!is_rd && dq_oe && beat >= 0 && beat < burst_len)
					mem[{base[21:4], 4'(beat)}] = dq_out;
				if (k >= rd_to_data + burst_len)
					data_on <= 1'b0;
			end
		end
	end

endmodule

//--- test/tb_mem_ctrl.sv
`timescale 1ns/100ps

module tb_mem_ctrl;
	import ddr_pkg::*;

	localparam int wait_limit = 4000;  // cycles allowed for any one wait
	localparam int num_tags   = 1 << tag_w;

	logic              clk;
	logic              rst_n;
	logic              rd_req, rd_ack, wr_req, wr_ack;
	addr_t             rd_addr, wr_addr;
	logic [tag_w-1:0]  rd_tag, wr_tag, rsp_tag;
	logic [data_w-1:0] wr_data, rsp_data, dq_out, dq_in;
	logic              rsp_req, rsp_ack, cs_n, dq_oe;
	req_kind_t         rsp_kind;
	logic [13:0]       ca;
	int                act_count;

	logic [data_w-1:0] shadow [logic [21:0]];  // completed writes only
	addr_t             done_addrs [$];
	logic              busy [num_tags];        // tag has a request outstanding
	req_kind_t         exp_kind [num_tags];
	addr_t             exp_addr [num_tags];
	logic [data_w-1:0] exp_data [num_tags];
	int                errors, checks, err_mark;
	string             test_name;
	bit                ack_jitter;

	mem_ctrl_top u_mem_ctrl_top (.*);
	ddr_mem_model u_ddr_mem_model (.*);

	always #4 clk = ~clk;

	function automatic logic [data_w-1:0] ref_read(addr_t a);
		if (shadow.exists(a))
			return shadow[a];
		return '0;
	endfunction

	task automatic check(input string item, input logic [data_w-1:0] exp,
		input logic [data_w-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[ERROR] %s %s expected %0h actual %0h", test_name, item, exp, act);
		end
	endtask

	task automatic give_up(input string what);
		$display("%s: gave up waiting, %s", test_name, what);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_mark  = errors;
	endtask

	task automatic end_test;
		$display("%s: %s, %0d errors", test_name, (errors == err_mark) ? "pass" : "fail",
			errors - err_mark);
	endtask

	task automatic next_cycle;
		@(posedge clk);
		#1;  // drive and sample away from the edge
	endtask

	// reads use tags 0..7, writes 8..15
	task automatic get_tag(input int first, output logic [tag_w-1:0] t);
		logic found;
		int   n;
		found = 1'b0;
		n     = 0;
		while (!found) begin
			for (int i = first; i < first + num_tags / 2; i++) begin
				if (!found && !busy[i]) begin
					t       = tag_w'(i);
					busy[i] = 1'b1;
					found   = 1'b1;
				end
			end
			if (!found) begin
				if (n == wait_limit)
					give_up("no free tag");
				n++;
				next_cycle();
			end
		end
	endtask

	task automatic send_req(input req_kind_t kind, input addr_t a, input logic [data_w-1:0] d);
		logic [tag_w-1:0] t;
		int               n;
		get_tag((kind == wr) ? num_tags / 2 : 0, t);
		exp_kind[t] = kind;
		exp_addr[t] = a;
		exp_data[t] = d;
		if (kind == wr) begin
			wr_addr = a;
			wr_data = d;
			wr_tag  = t;
			wr_req  = 1'b1;
		end else begin
			rd_addr = a;
			rd_tag  = t;
			rd_req  = 1'b1;
		end
		n = 0;
		while (!((kind == wr) ? wr_ack : rd_ack)) begin
			if (n == wait_limit)
				give_up("request ack never rose");
			n++;
			next_cycle();
		end
		if (kind == wr)
			wr_req = 1'b0;
		else
			rd_req = 1'b0;
		n = 0;
		while ((kind == wr) ? wr_ack : rd_ack) begin
			if (n == wait_limit)
				give_up("request ack never fell");
			n++;
			next_cycle();
		end
	endtask

	task automatic wait_idle;
		int n;
		n = 0;
		while (busy.sum() with (int'(item)) != 0) begin
			if (n == wait_limit)
				give_up("responses still outstanding");
			n++;
			next_cycle();
		end
	endtask

	// host side of the response handshake, checks every response
	initial begin : rsp_check
		logic [tag_w-1:0] t;
		int               n;
		int               gap;
		rsp_ack = 1'b0;
		forever begin
			next_cycle();
			if (rsp_req && !rsp_ack) begin
				t = rsp_tag;
				check("tag outstanding", 1, busy[t]);
				if (busy[t]) begin
					check("rsp_kind", exp_kind[t], rsp_kind);
					if (exp_kind[t] == wr) begin
						shadow[exp_addr[t]] = exp_data[t];
						done_addrs.push_back(exp_addr[t]);
					end else begin
						check("rsp_data", ref_read(exp_addr[t]), rsp_data);
					end
					busy[t] = 1'b0;
				end
				gap = ack_jitter ? $urandom % 4 : 0;
				repeat (gap)
					next_cycle();
				rsp_ack = 1'b1;
				n = 0;
				while (rsp_req) begin
					if (n == wait_limit)
						give_up("rsp_req never fell");
					n++;
					next_cycle();
				end
				rsp_ack = 1'b0;
			end
		end
	end

	initial begin : main_flow
		addr_t             a, wa, ra;
		logic [burst_len-1:0] mask;
		logic [data_w-1:0] d;
		int                acts;
		void'($urandom(32'h689fbe77));
		clk = 1'b0;
		rst_n = 1'b1;
		rd_req = 1'b0;
		wr_req = 1'b0;
		rd_addr = '0;
		wr_addr = '0;
		rd_tag = '0;
		wr_tag = '0;
		wr_data = '0;
		errors = 0;
		checks = 0;
		ack_jitter = 1'b0;
		busy = '{default: 1'b0};
		repeat (10)
			@(posedge clk);
		#1 rst_n = 1'b0;

		start_test("idle");
		repeat (40) begin
			next_cycle();
			check("cs_n", 1, cs_n);
			check("dq_oe", 0, dq_oe);
			check("rsp_req", 0, rsp_req);
			check("acks", 0, {rd_ack, wr_ack});
		end
		end_test();

		start_test("single_rw");
		a = 22'($urandom);
		send_req(wr, a, $urandom);
		wait_idle();
		send_req(rd, a, '0);
		wait_idle();
		end_test();

		start_test("block_rw");
		a = 22'($urandom);
		acts = act_count;
		for (int b = 0; b < burst_len; b++) begin
			a.column[beat_w-1:0] = beat_w'(b);
			send_req(wr, a, $urandom);
		end
		wait_idle();
		for (int b = 0; b < burst_len; b++) begin
			a.column[beat_w-1:0] = beat_w'(b);
			send_req(rd, a, '0);
		end
		wait_idle();
		// the arbiter leaves a gap after every beat, so each request closes its own burst
		check("activates", 2 * burst_len, act_count - acts);
		end_test();

		start_test("partial");
		repeat (3) begin
			a = 22'($urandom);
			mask = burst_len'($urandom);
			for (int b = 0; b < burst_len; b++) begin
				a.column[beat_w-1:0] = beat_w'(b);
				if (mask[b])
					send_req(wr, a, $urandom);
			end
			wait_idle();
			for (int b = 0; b < burst_len; b++) begin
				a.column[beat_w-1:0] = beat_w'(b);
				send_req(rd, a, '0);
			end
			wait_idle();
		end
		end_test();

		start_test("mixed");
		ack_jitter = 1'b1;
		fork
			for (int i = 0; i < 12; i++) begin
				do begin
					wa = 22'($urandom);
					wa.bank = i[1:0];
					wa.column = i[5:0];  // keeps this test's writes apart
				end while (shadow.exists(wa));
				d = $urandom;
				send_req(wr, wa, d);
				repeat ($urandom % 3)
					next_cycle();
			end
			for (int i = 0; i < 12; i++) begin
				ra = done_addrs[$urandom % done_addrs.size()];
				send_req(rd, ra, '0);
				repeat ($urandom % 3)
					next_cycle();
			end
		join
		wait_idle();
		ack_jitter = 1'b0;
		end_test();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
